// File: verilog/ipod_macros.svh
`ifndef IPOD_MACROS_SVH
`define IPOD_MACROS_SVH

// ============================================================
// Sample period settings, in CLK_50M cycles
// ============================================================

// Roughly 44 kHz at 50 MHz
`define DEFAULT_SAMPLE_PERIOD 16'd1136
// Change per button event
`define SPEED_STEP 16'd100
// Clamp limits
`define MIN_SAMPLE_PERIOD 16'd136
`define MAX_SAMPLE_PERIOD 16'd9136

// Auto-repeat spacing, about ten events per second
`define DEFAULT_REPEAT_CYCLES 5000000

// Last 32-bit flash word holding the song
`define LAST_WORD_ADDR 23'h7FFFF

// ASCII command bytes
`define CMD_PLAY 8'h45
`define CMD_PAUSE 8'h44
`define CMD_FWD 8'h46
`define CMD_BWD 8'h42
`define CMD_RESTART 8'h52

`endif

// File: verilog/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // Widths with a meaning
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;
  typedef logic signed [15:0] sample_t;
  typedef logic [15:0] period_t;
  typedef logic [7:0] ascii_t;
  // Active-low segments, gfedcba
  typedef logic [6:0] seg_t;

  // Flash read request, Avalon style
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  // Flash response side
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  // Command byte with valid
  typedef struct packed {
    logic   valid;
    ascii_t char;
  } cmd_t;

  // One audio sample, valid for a single cycle
  typedef struct packed {
    logic    valid;
    sample_t sample;
  } audio_t;

  // Player FSM
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT_DATA,
    FIRST_HALF,
    SECOND_HALF
  } player_state_t;

endpackage

`default_nettype wire

// File: verilog/button_conditioner.sv
`timescale 1ns/100ps
`default_nettype none
`include "ipod_macros.svh"

module button_conditioner #(
  parameter int unsigned REPEAT_CYCLES = `DEFAULT_REPEAT_CYCLES
) (
  input  logic CLK_50M,
  input  logic rst_n,
  input  logic key_n,
  output logic event_pulse
);

  localparam int CNT_W = $clog2(REPEAT_CYCLES + 1);

  // Two-stage synchronizer, key inverted to active high
  logic [1:0]       key_sync;
  // Previous synchronized level, for edge detection
  logic             pressed_d;
  // Cycles since the last event while held
  logic [CNT_W-1:0] rep_cnt;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_sync    <= 2'b00;
      pressed_d   <= 1'b0;
      rep_cnt     <= '0;
      event_pulse <= 1'b0;
    end
    else
    begin
      key_sync    <= {key_sync[0], ~key_n};
      pressed_d   <= key_sync[1];
      event_pulse <= 1'b0;
      // Released, stop at once
      if (!key_sync[1])
        rep_cnt <= '0;
      // Press edge
      else if (!pressed_d)
      begin
        rep_cnt     <= '0;
        event_pulse <= 1'b1;
      end
      // Held long enough, repeat
      else if (rep_cnt == CNT_W'(REPEAT_CYCLES - 1))
      begin
        rep_cnt     <= '0;
        event_pulse <= 1'b1;
      end
      else
        rep_cnt <= rep_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sample_rate_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "ipod_macros.svh"

module sample_rate_ctrl import ipod_pkg::*; (
  input  logic    CLK_50M,
  input  logic    rst_n,
  input  logic    faster,
  input  logic    slower,
  input  logic    set_default,
  output period_t period,
  output logic    sample_tick
);

  // Period after this cycle's events
  period_t period_next;
  // Cycles left until the next tick
  period_t tick_cnt;

  // Default beats faster, faster beats slower
  always_comb
  begin
    period_next = period;
    if (set_default)
      period_next = `DEFAULT_SAMPLE_PERIOD;
    else if (faster)
    begin
      if (period < `MIN_SAMPLE_PERIOD + `SPEED_STEP)
        period_next = `MIN_SAMPLE_PERIOD;
      else
        period_next = period - `SPEED_STEP;
    end
    else if (slower)
    begin
      if (period > `MAX_SAMPLE_PERIOD - `SPEED_STEP)
        period_next = `MAX_SAMPLE_PERIOD;
      else
        period_next = period + `SPEED_STEP;
    end
  end

  // ============================================================
  // Period register and tick down-counter
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      period      <= `DEFAULT_SAMPLE_PERIOD;
      tick_cnt    <= `DEFAULT_SAMPLE_PERIOD - 16'd1;
      sample_tick <= 1'b0;
    end
    else
    begin
      period      <= period_next;
      sample_tick <= 1'b0;
      // New period, count starts over
      if (period_next != period)
        tick_cnt <= period_next - 16'd1;
      else if (tick_cnt == '0)
      begin
        tick_cnt    <= period - 16'd1;
        sample_tick <= 1'b1;
      end
      else
        tick_cnt <= tick_cnt - 16'd1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/flash_player.sv
`timescale 1ns/100ps
`default_nettype none
`include "ipod_macros.svh"

module flash_player import ipod_pkg::*; (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  cmd_t       cmd,
  output logic       cmd_ready,
  input  logic       sample_tick,
  output flash_req_t flash_req,
  input  flash_rsp_t flash_rsp,
  output audio_t     audio
);

  player_state_t state;
  flash_addr_t   addr;
  flash_addr_t   next_addr;
  // Current 32-bit word, two samples
  flash_word_t   word;
  // 1 = forward, 0 = backward
  logic          fwd;
  // Tick seen while fetching
  logic          pend_tick;
  // Pause waiting for the current sample
  logic          pause_req;
  logic          audio_valid;
  sample_t       audio_sample;

  logic          cmd_take;
  logic          playing;
  logic          emit;
  logic          pause_now;
  logic          sel_high;

  // No commands while a read is outstanding
  assign cmd_ready = (state != FETCH) && (state != WAIT_DATA);
  assign cmd_take  = cmd.valid && cmd_ready;
  assign playing   = (state == FIRST_HALF) || (state == SECOND_HALF);
  assign emit      = playing && (sample_tick || pend_tick);
  assign pause_now = pause_req || (cmd_take && cmd.char == `CMD_PAUSE);
  // Forward plays low half first, backward high half first
  assign sel_high  = (state == FIRST_HALF) ? !fwd : fwd;

  // Wrap between 0 and the last song word
  assign next_addr = fwd ? ((addr == `LAST_WORD_ADDR) ? '0 : addr + 1'b1)
                         : ((addr == '0) ? `LAST_WORD_ADDR : addr - 1'b1);

  // Read only in FETCH, address held by the FSM
  assign flash_req = '{read: (state == FETCH), address: addr};
  assign audio     = '{valid: audio_valid, sample: audio_sample};

  // ============================================================
  // Player FSM
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state       <= IDLE;
      addr        <= '0;
      fwd         <= 1'b1;
      pend_tick   <= 1'b0;
      pause_req   <= 1'b0;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= emit;
      // At most one tick kept across the fetch
      if ((state == FETCH) || (state == WAIT_DATA))
      begin
        if (sample_tick)
          pend_tick <= 1'b1;
      end
      else
        pend_tick <= 1'b0;

      case (state)
        IDLE: ;
        FETCH:
          if (!flash_rsp.waitrequest)
            state <= WAIT_DATA;
        WAIT_DATA:
          if (flash_rsp.readdatavalid)
            state <= FIRST_HALF;
        FIRST_HALF:
          if (emit)
          begin
            state     <= pause_now ? IDLE : SECOND_HALF;
            pause_req <= 1'b0;
          end
        SECOND_HALF:
          if (emit)
          begin
            addr      <= next_addr;
            state     <= pause_now ? IDLE : FETCH;
            pause_req <= 1'b0;
          end
        default: state <= IDLE;
      endcase

      // Commands override the FSM step
      if (cmd_take)
      begin
        case (cmd.char)
          `CMD_PLAY:
          begin
            pause_req <= 1'b0;
            if (state == IDLE)
              state <= FETCH;
          end
          `CMD_PAUSE:
            if (playing && !emit)
              pause_req <= 1'b1;
          `CMD_FWD: fwd <= 1'b1;
          `CMD_BWD: fwd <= 1'b0;
          `CMD_RESTART:
          begin
            addr <= fwd ? '0 : `LAST_WORD_ADDR;
            // Drop the current word
            if (playing)
              state <= FETCH;
          end
          default: ;
        endcase
      end
    end
  end

  // Data path, no reset
  always_ff @(posedge CLK_50M)
  begin
    if ((state == WAIT_DATA) && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
    if (emit)
      audio_sample <= sample_t'(sel_high ? word[31:16] : word[15:0]);
  end

endmodule

`default_nettype wire

// File: verilog/hex_display.sv
`timescale 1ns/100ps
`default_nettype none
`include "ipod_macros.svh"

module hex_display import ipod_pkg::*; (
  input  logic    CLK_50M,
  input  logic    rst_n,
  input  period_t period,
  output seg_t    hex0,
  output seg_t    hex1,
  output seg_t    hex2,
  output seg_t    hex3,
  output seg_t    hex4,
  output seg_t    hex5
);

  // Six nibbles, top two always zero
  localparam logic [23:0] RST_DIGITS = {8'h00, `DEFAULT_SAMPLE_PERIOD};

  logic [23:0] digits;
  seg_t        hex_q [6];

  // Standard 0-F patterns, active low
  function automatic seg_t seg_of(input logic [3:0] nib);
    case (nib)
      4'h0: seg_of = 7'b1000000;
      4'h1: seg_of = 7'b1111001;
      4'h2: seg_of = 7'b0100100;
      4'h3: seg_of = 7'b0110000;
      4'h4: seg_of = 7'b0011001;
      4'h5: seg_of = 7'b0010010;
      4'h6: seg_of = 7'b0000010;
      4'h7: seg_of = 7'b1111000;
      4'h8: seg_of = 7'b0000000;
      4'h9: seg_of = 7'b0010000;
      4'hA: seg_of = 7'b0001000;
      4'hB: seg_of = 7'b0000011;
      4'hC: seg_of = 7'b1000110;
      4'hD: seg_of = 7'b0100001;
      4'hE: seg_of = 7'b0000110;
      default: seg_of = 7'b0001110;
    endcase
  endfunction

  assign digits = {8'h00, period};

  // Shows the reset period while in reset
  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < 6; i++)
    begin
      if (!rst_n)
        hex_q[i] <= seg_of(RST_DIGITS[4*i +: 4]);
      else
        hex_q[i] <= seg_of(digits[4*i +: 4]);
    end
  end

  assign hex0 = hex_q[0];
  assign hex1 = hex_q[1];
  assign hex2 = hex_q[2];
  assign hex3 = hex_q[3];
  assign hex4 = hex_q[4];
  assign hex5 = hex_q[5];

endmodule

`default_nettype wire

// File: verilog/ipod_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "ipod_macros.svh"

module ipod_top import ipod_pkg::*; #(
  parameter int unsigned REPEAT_CYCLES = `DEFAULT_REPEAT_CYCLES
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic       key_faster,
  input  logic       key_slower,
  input  logic       key_default,
  input  cmd_t       cmd,
  output logic       cmd_ready,
  output flash_req_t flash_req,
  input  flash_rsp_t flash_rsp,
  output audio_t     audio,
  output seg_t       hex0,
  output seg_t       hex1,
  output seg_t       hex2,
  output seg_t       hex3,
  output seg_t       hex4,
  output seg_t       hex5
);

  // Bit 0 faster, bit 1 slower, bit 2 default
  logic [2:0] keys_n;
  logic [2:0] events;
  period_t    period;
  logic       sample_tick;

  assign keys_n = {key_default, key_slower, key_faster};

  // ============================================================
  // Key conditioning, one per button
  // ============================================================
  genvar gi;
  generate
    for (gi = 0; gi < 3; gi++)
    begin : g_btn
      button_conditioner #(
        .REPEAT_CYCLES(REPEAT_CYCLES)
      ) u_button_conditioner (
        .CLK_50M    (CLK_50M),
        .rst_n      (rst_n),
        .key_n      (keys_n[gi]),
        .event_pulse(events[gi])
      );
    end
  endgenerate

  sample_rate_ctrl u_sample_rate_ctrl (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .faster     (events[0]),
    .slower     (events[1]),
    .set_default(events[2]),
    .period     (period),
    .sample_tick(sample_tick)
  );

  // Playback from flash
  flash_player u_flash_player (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .sample_tick(sample_tick),
    .flash_req  (flash_req),
    .flash_rsp  (flash_rsp),
    .audio      (audio)
  );

  // Period shown in hex
  hex_display u_hex_display (
    .CLK_50M(CLK_50M),
    .rst_n  (rst_n),
    .period (period),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5)
  );

endmodule

`default_nettype wire

// File: sim/tb_ipod_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "ipod_macros.svh"

module tb_ipod_top import ipod_pkg::*;;

  logic CLK_50M = 1'b0;
  logic rst_n, key_faster, key_slower, key_default, cmd_ready;
  cmd_t cmd;
  flash_req_t flash_req;
  flash_rsp_t flash_rsp;
  audio_t audio;
  seg_t hex0, hex1, hex2, hex3, hex4, hex5;
  logic [41:0] disp;
  // Random source and flash model state
  logic [15:0] lfsr = 16'd28;
  logic [1:0] stall, delay;
  logic issued, busy, init_phase, paused;
  flash_addr_t rd_addr;
  // Reference playback model
  flash_addr_t m_addr;
  logic m_fwd, m_first, m_hi;
  logic [15:0] m_exp;
  int n_samples, pause_base, p;

  ipod_top #(.REPEAT_CYCLES(40)) u_ipod_top (
    .CLK_50M(CLK_50M), .rst_n(rst_n), .key_faster(key_faster), .key_slower(key_slower),
    .key_default(key_default), .cmd(cmd), .cmd_ready(cmd_ready), .flash_req(flash_req),
    .flash_rsp(flash_rsp), .audio(audio), .hex0(hex0), .hex1(hex1), .hex2(hex2),
    .hex3(hex3), .hex4(hex4), .hex5(hex5)
  );

  always #10 CLK_50M = ~CLK_50M;
  assign disp = {hex5, hex4, hex3, hex2, hex1, hex0};

  task automatic fail_now(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic time_out(input string what);
    $display("Timed out while waiting for %s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [15:0] lfsr_step(input logic [15:0] x);
    lfsr_step = x[0] ? ((x >> 1) ^ 16'hB400) : (x >> 1);
  endfunction

  // Active-low gfedcba patterns for 0-F
  function automatic seg_t seg_pat(input logic [3:0] n);
    logic [6:0] tbl [16];
    tbl = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
            7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    seg_pat = tbl[n];
  endfunction

  function automatic logic [41:0] disp_of(input int val);
    logic [23:0] d;
    d = 24'(val);
    disp_of = {seg_pat(d[23:20]), seg_pat(d[19:16]), seg_pat(d[15:12]),
               seg_pat(d[11:8]), seg_pat(d[7:4]), seg_pat(d[3:0])};
  endfunction

  // Song address step with wrap at both ends
  function automatic flash_addr_t addr_step(input flash_addr_t a, input logic fwd);
    if (fwd)
      addr_step = (a == `LAST_WORD_ADDR) ? '0 : a + 1'b1;
    else
      addr_step = (a == '0) ? `LAST_WORD_ADDR : a - 1'b1;
  endfunction

  // ============================================================
  // Flash model, random stall and return delay
  // ============================================================
  always @(posedge CLK_50M)
  begin
    flash_rsp.readdatavalid <= 1'b0;
    if (flash_req.read && !flash_rsp.waitrequest && !issued)
    begin
      issued <= 1'b1;
      rd_addr <= flash_req.address;
      flash_rsp.waitrequest <= 1'b1;
      lfsr = lfsr_step(lfsr_step(lfsr));
      stall <= lfsr[1:0];
      lfsr = lfsr_step(lfsr_step(lfsr));
      delay <= lfsr[1:0];
    end
    else if (flash_req.read && flash_rsp.waitrequest && !issued)
    begin
      if (stall == 2'd0)
        flash_rsp.waitrequest <= 1'b0;
      else
        stall <= stall - 2'd1;
    end
    if (issued)
    begin
      if (delay == 2'd0)
      begin
        issued <= 1'b0;
        flash_rsp.readdatavalid <= 1'b1;
        flash_rsp.readdata <= {~rd_addr[15:0], rd_addr[15:0]};
      end
      else
        delay <= delay - 2'd1;
    end
    // Outstanding from acceptance until data returns
    if (flash_req.read && !flash_rsp.waitrequest)
      busy <= 1'b1;
    else if (flash_rsp.readdatavalid)
      busy <= 1'b0;
  end

  // Sample order against the model
  always @(posedge CLK_50M)
  begin
    if (rst_n && audio.valid)
    begin
      m_hi = m_first ? !m_fwd : m_fwd;
      m_exp = m_hi ? ~m_addr[15:0] : m_addr[15:0];
      assert (audio.sample == m_exp)
      else
        fail_now($sformatf("sample %h, expected %h", audio.sample, m_exp));
      if (!m_first)
        m_addr = addr_step(m_addr, m_fwd);
      m_first = !m_first;
      n_samples <= n_samples + 1;
    end
  end

  // ============================================================
  // Assertions
  // ============================================================
  a_init: assert property (@(posedge CLK_50M) disable iff (!rst_n) init_phase |->
    (!flash_req.read && !audio.valid && cmd_ready && disp == disp_of(1136)))
    else fail_now("state after reset wrong");
  a_disp: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    disp == disp_of($past(u_ipod_top.period))) else fail_now("display off period");
  a_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    u_ipod_top.period >= 136 && u_ipod_top.period <= 9136) else fail_now("period out of range");
  a_hold: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
    else fail_now("read request changed during stall");
  a_one_rd: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    busy |-> !flash_req.read) else fail_now("second read before data");
  a_ready: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    cmd_ready == !(flash_req.read || busy)) else fail_now("cmd_ready mismatch");
  a_gap: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    audio.valid |=> !audio.valid) else fail_now("back-to-back samples");
  a_pause: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    paused |-> n_samples <= pause_base + 1) else fail_now("samples during pause");

  task automatic wait_period(input int val, input int limit);
    int i;
    for (i = 0; i < limit; i++)
    begin
      @(posedge CLK_50M);
      if (disp == disp_of(val))
        return;
    end
    time_out($sformatf("display period %0d", val));
  endtask

  task automatic wait_samples(input int target, input int limit);
    int i;
    for (i = 0; i < limit && n_samples < target; i++)
      @(posedge CLK_50M);
    if (n_samples < target)
      time_out("audio samples");
  endtask

  // Holds valid until the byte is taken
  task automatic send_cmd(input ascii_t c);
    int i;
    @(posedge CLK_50M);
    cmd <= '{valid: 1'b1, char: c};
    for (i = 0; i < 200; i++)
    begin
      @(posedge CLK_50M);
      if (cmd_ready)
      begin
        cmd <= '{valid: 1'b0, char: 8'h00};
        return;
      end
    end
    time_out("cmd_ready");
  endtask

  initial
  begin
    int i;
    rst_n <= 1'b0;
    key_faster <= 1'b1;
    key_slower <= 1'b1;
    key_default <= 1'b1;
    cmd <= '0;
    flash_rsp <= '{waitrequest: 1'b1, readdatavalid: 1'b0, readdata: '0};
    {issued, busy, paused, stall, delay, n_samples, pause_base} = '0;
    init_phase = 1'b1;
    m_addr = '0;
    m_fwd = 1'b1;
    m_first = 1'b1;
    repeat (4) @(posedge CLK_50M);
    rst_n <= 1'b1;
    repeat (20) @(posedge CLK_50M);
    init_phase = 1'b0;
    // Wrap rule of the model
    if (addr_step(`LAST_WORD_ADDR, 1'b1) != '0)
      fail_now("forward wrap rule");
    // Single tap of faster, period in 4 cycles and display one later
    key_faster <= 1'b0;
    wait_period(1036, 6);
    key_faster <= 1'b1;
    // Hold slower up to the clamp
    key_slower <= 1'b0;
    for (p = 1136; p <= 9136; p += 100)
      wait_period(p, 80);
    repeat (200) @(posedge CLK_50M);
    key_slower <= 1'b1;
    // Hold faster down to the clamp
    key_faster <= 1'b0;
    for (p = 9036; p >= 136; p -= 100)
      wait_period(p, 80);
    repeat (200) @(posedge CLK_50M);
    key_faster <= 1'b1;
    repeat (10) @(posedge CLK_50M);
    key_default <= 1'b0;
    wait_period(1136, 6);
    key_default <= 1'b1;
    // Back to the fastest rate for playback
    key_faster <= 1'b0;
    wait_period(136, 4000);
    key_faster <= 1'b1;
    // Forward play, then pause
    send_cmd(`CMD_PLAY);
    wait_samples(8, 3000);
    send_cmd(`CMD_PAUSE);
    // Sample showing at the take edge came before the pause
    pause_base = audio.valid ? n_samples + 1 : n_samples;
    paused = 1'b1;
    repeat (600) @(posedge CLK_50M);
    // Backward from the song end
    send_cmd(`CMD_BWD);
    send_cmd(`CMD_RESTART);
    m_addr = `LAST_WORD_ADDR;
    m_fwd = 1'b0;
    m_first = 1'b1;
    paused = 1'b0;
    send_cmd(`CMD_PLAY);
    wait_samples(n_samples + 6, 3000);
    // Pause held across a stall, taken once ready rises
    for (i = 0; i < 500 && !flash_req.read; i++)
      @(posedge CLK_50M);
    if (!flash_req.read)
      time_out("flash read");
    send_cmd(`CMD_PAUSE);
    pause_base = audio.valid ? n_samples + 1 : n_samples;
    paused = 1'b1;
    repeat (600) @(posedge CLK_50M);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: ipod_top.f
+incdir+verilog
verilog/ipod_pkg.sv
verilog/button_conditioner.sv
verilog/sample_rate_ctrl.sv
verilog/flash_player.sv
verilog/hex_display.sv
verilog/ipod_top.sv
sim/tb_ipod_top.sv

// File: Makefile
# Verilator flow for the playback core
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_ipod_top
RTL_TOP   ?= ipod_top
FILELIST  ?= ipod_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing +incdir+verilog --top-module $(RTL_TOP) \
		verilog/ipod_pkg.sv verilog/button_conditioner.sv verilog/sample_rate_ctrl.sv \
		verilog/flash_player.sv verilog/hex_display.sv verilog/ipod_top.sv

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
